/* spif_cfg_pkg.sv */
package spif_cfg_pkg;

  // ========================================
  // cpu side sizes
  // ========================================
  localparam int WIDTH  = 24;                  // cpu data word
  localparam int ADDR_W = 15;                  // io address bits

  // ========================================
  // wishbone side sizes
  // ========================================
  localparam int WB_DATA_W = 32;               // bus data word
  localparam int XTRA_W    = WB_DATA_W - WIDTH; // bits above a cpu word

  // word types built on the sizes
  typedef logic [WIDTH-1:0]     word_t;        // cpu data word
  typedef logic [ADDR_W-1:0]    addr_t;        // cpu io address
  typedef logic [WB_DATA_W-1:0] wb_data_t;     // full bus word
  typedef logic [XTRA_W-1:0]    xtra_t;        // upper bus bits
  typedef logic [7:0]           byte_t;        // one uart byte

endpackage

/* spif_io_pkg.sv */
package spif_io_pkg;

  typedef logic [3:0] reg_ofs_t;               // offset inside the internal page

  // ========================================
  // internal register map
  // ========================================
  localparam reg_ofs_t REG_UART    = 4'h0;     // tx byte out, rx byte in
  localparam reg_ofs_t REG_RXFULL  = 4'h1;     // rx buffer holds a byte
  localparam reg_ofs_t REG_TXBUSY  = 4'h2;     // tx path can't take a byte
  localparam reg_ofs_t REG_CYCLES  = 4'h6;     // free-running counter
  localparam reg_ofs_t REG_WBX     = 4'h7;     // upper wishbone bits
  localparam reg_ofs_t REG_PRODUCT = 4'hE;     // product id

  // everything from here up goes out on wishbone
  localparam spif_cfg_pkg::addr_t INTERNAL_LIMIT = 15'h0010;

  // ========================================
  // uart stream escape codes
  // ========================================
  localparam spif_cfg_pkg::byte_t ESC_BYTE = 8'h10; // escape prefix
  localparam logic [5:0] ESC_TOP6 = 6'b000100; // 10h..13h need escaping
  localparam logic [1:0] ESC_LIT  = 2'b00;     // prefix low bits, literal follows

  localparam logic [15:0] PRODUCT_ID = 16'h0001;

endpackage

/* uart_tx_escaper.sv */
`timescale 1ns/1ps

module uart_tx_escaper (
  input  logic                clk,
  input  logic                arstn,
  input  logic                i_tx_valid,  // byte offered by the register block
  input  spif_cfg_pkg::byte_t i_tx_data,
  input  logic                i_u_ready,   // uart can take a byte
  output logic                o_tx_ready,
  output logic                o_u_wr,      // one-cycle transmit strobe
  output spif_cfg_pkg::byte_t o_u_dout
);

  logic       pend;                        // suffix byte still owed
  logic [1:0] low;                         // saved low bits for the suffix
  logic       esc_hit;                     // incoming byte is 10h..13h
  logic       take;                        // handshake completes this edge
  logic       suffix_go;                   // suffix goes out this edge

  assign esc_hit    = (i_tx_data[7:2] == spif_io_pkg::ESC_TOP6);
  assign o_tx_ready = i_u_ready & ~pend & ~o_u_wr; // no back-to-back strobes
  assign take       = i_tx_valid & o_tx_ready;
  assign suffix_go  = pend & i_u_ready & ~o_u_wr;

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      o_u_wr <= 1'b0;
      pend   <= 1'b0;
    end else begin
      o_u_wr <= take | suffix_go;          // strobe lasts one cycle
      if (take)
        pend <= esc_hit;                   // escaped byte owes a suffix
      else if (suffix_go)
        pend <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      low      <= i_tx_data[1:0];
      o_u_dout <= esc_hit ? spif_io_pkg::ESC_BYTE : i_tx_data; // prefix or plain
    end else if (suffix_go) begin
      o_u_dout <= {6'b000000, low};        // 00h..03h
    end
  end

endmodule

/* uart_rx_unescaper.sv */
`timescale 1ns/1ps

module uart_rx_unescaper (
  input  logic                clk,
  input  logic                arstn,
  input  logic                i_u_full,    // uart holds a raw byte
  input  spif_cfg_pkg::byte_t i_u_din,
  input  logic                i_rx_ready,  // rx buffer empty
  output logic                o_u_rd,      // one-cycle take strobe
  output logic                o_rx_valid,  // decoded byte, same cycle as o_u_rd
  output spif_cfg_pkg::byte_t o_rx_data
);

  typedef enum logic {ST_IDLE, ST_ESC} st_t;

  st_t                 st, st_nxt;
  logic                rd_nxt;
  logic                vld_nxt;
  spif_cfg_pkg::byte_t data_nxt;

  // ========================================
  // decode the next raw byte
  // ========================================
  always_comb begin
    st_nxt   = st;
    rd_nxt   = 1'b0;
    vld_nxt  = 1'b0;
    data_nxt = i_u_din;
    if (i_u_full && !o_u_rd) begin         // skip cycle after a take
      if (st == ST_ESC) begin
        if (i_rx_ready) begin              // suffix waits for buffer space
          rd_nxt   = 1'b1;
          vld_nxt  = 1'b1;
          data_nxt = spif_io_pkg::ESC_BYTE | {6'b000000, i_u_din[1:0]};
          st_nxt   = ST_IDLE;
        end
      end else if (i_u_din[7:2] == spif_io_pkg::ESC_TOP6) begin
        rd_nxt = 1'b1;                     // 10h..13h always swallowed
        if (i_u_din[1:0] == spif_io_pkg::ESC_LIT)
          st_nxt = ST_ESC;                 // only 10h starts a literal
      end else if (i_rx_ready) begin
        rd_nxt  = 1'b1;                    // plain data byte
        vld_nxt = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      st         <= ST_IDLE;
      o_u_rd     <= 1'b0;
      o_rx_valid <= 1'b0;
    end else begin
      st         <= st_nxt;
      o_u_rd     <= rd_nxt;
      o_rx_valid <= vld_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (vld_nxt)
      o_rx_data <= data_nxt;
  end

endmodule

/* wb_master_bridge.sv */
`timescale 1ns/1ps

module wb_master_bridge (
  input  logic                   clk,
  input  logic                   arstn,
  input  logic                   i_req,    // external access from the cpu
  input  logic                   i_we,     // 1 = write
  input  spif_cfg_pkg::addr_t    i_addr,
  input  spif_cfg_pkg::word_t    i_din,
  input  spif_cfg_pkg::xtra_t    i_xo,     // upper outgoing bits
  input  spif_cfg_pkg::wb_data_t i_dat,    // slave read data
  input  logic                   i_ack,
  output logic                   o_busy,
  output spif_cfg_pkg::wb_data_t o_xi,     // last captured read word
  output spif_cfg_pkg::addr_t    o_adr,
  output spif_cfg_pkg::wb_data_t o_dat,
  output logic                   o_we,
  output logic                   o_stb
);

  logic start;                             // new cycle launched this edge

  assign start  = i_req & ~o_stb;          // one access outstanding at most
  assign o_busy = o_stb;

  // ========================================
  // strobe and read capture
  // ========================================
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      o_stb <= 1'b0;
      o_we  <= 1'b0;
      o_xi  <= '0;
    end else if (o_stb) begin
      if (i_ack) begin                     // slave done
        o_stb <= 1'b0;
        if (!o_we)
          o_xi <= i_dat;                   // read data lands here
      end
    end else if (start) begin
      o_stb <= 1'b1;
      o_we  <= i_we;
    end
  end

  // address and write word, latched at launch
  always_ff @(posedge clk) begin
    if (start) begin
      o_adr <= i_addr;
      o_dat <= {i_xo, i_din};              // extra bits on top of cpu word
    end
  end

endmodule

/* io_regs.sv */
`timescale 1ns/1ps

module io_regs (
  input  logic                   clk,
  input  logic                   arstn,
  input  logic                   i_io_rd,   // cpu io read strobe
  input  logic                   i_io_wr,   // cpu io write strobe
  input  spif_cfg_pkg::addr_t    i_mem_addr,
  input  spif_cfg_pkg::word_t    i_din,
  input  logic                   i_tx_ready,
  input  logic                   i_rx_valid,
  input  spif_cfg_pkg::byte_t    i_rx_data,
  input  logic                   i_wb_busy,
  input  spif_cfg_pkg::wb_data_t i_wb_xi,   // captured bus read word
  output spif_cfg_pkg::word_t    o_io_dout,
  output logic                   o_p_hold,  // cpu wait state
  output logic                   o_tx_valid,
  output spif_cfg_pkg::byte_t    o_tx_data,
  output logic                   o_rx_ready,
  output logic                   o_wb_req,
  output logic                   o_wb_we,
  output spif_cfg_pkg::xtra_t    o_wb_xo,
  output logic                   o_urxirq   // rx byte arrived
);

  spif_io_pkg::reg_ofs_t ofs;               // offset in the internal page
  logic                  internal;          // below 10h
  logic                  uart_wr;           // cpu writing the uart register
  logic                  rd_go;             // internal read completes
  logic                  wr_go;             // internal write completes
  logic                  rx_take;           // decoded byte enters buffer
  spif_cfg_pkg::byte_t   rx_byte;           // rx buffer
  logic                  rx_full;
  logic                  rx_full_d;         // for the irq edge
  spif_cfg_pkg::xtra_t   wbxo;              // upper outgoing bus bits
  spif_cfg_pkg::word_t   cycles;            // free-running
  spif_cfg_pkg::word_t   reg_dout;          // internal read mux

  assign ofs      = i_mem_addr[3:0];
  assign internal = (i_mem_addr < spif_io_pkg::INTERNAL_LIMIT);
  assign rd_go    = i_io_rd & internal & ~o_p_hold;
  assign wr_go    = i_io_wr & internal & ~o_p_hold;

  // ========================================
  // wait states and block handoff
  // ========================================
  assign uart_wr    = i_io_wr & internal & (ofs == spif_io_pkg::REG_UART);
  assign o_tx_valid = uart_wr & ~i_wb_busy;  // hold stays up while bus busy
  assign o_tx_data  = i_din[7:0];
  assign o_p_hold   = (uart_wr & ~i_tx_ready) | i_wb_busy;
  assign o_wb_req   = ~internal & (i_io_rd | i_io_wr) & ~o_p_hold;
  assign o_wb_we    = i_io_wr;
  assign o_wb_xo    = wbxo;

  assign rx_take    = i_rx_valid & o_rx_ready;
  assign o_rx_ready = ~rx_full;
  assign o_urxirq   = rx_full & ~rx_full_d;   // one cycle after the flag rises

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      rx_full   <= 1'b0;
      rx_full_d <= 1'b0;
      wbxo      <= '0;
      cycles    <= '0;
    end else begin
      rx_full_d <= rx_full;
      cycles    <= cycles + 1'b1;
      if (rd_go && ofs == spif_io_pkg::REG_UART)
        rx_full <= 1'b0;                    // reading the byte frees the buffer
      if (rx_take)
        rx_full <= 1'b1;
      if (wr_go && ofs == spif_io_pkg::REG_WBX)
        wbxo <= i_din[spif_cfg_pkg::XTRA_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rx_take)
      rx_byte <= i_rx_data;
  end

  // ========================================
  // read mux
  // ========================================
  always_comb begin
    case (ofs)
      spif_io_pkg::REG_UART:    reg_dout = spif_cfg_pkg::word_t'(rx_byte);
      spif_io_pkg::REG_RXFULL:  reg_dout = spif_cfg_pkg::word_t'(rx_full);
      spif_io_pkg::REG_TXBUSY:  reg_dout = spif_cfg_pkg::word_t'(~i_tx_ready);
      spif_io_pkg::REG_CYCLES:  reg_dout = cycles;
      spif_io_pkg::REG_WBX:
        reg_dout = spif_cfg_pkg::word_t'(i_wb_xi[spif_cfg_pkg::WB_DATA_W-1:spif_cfg_pkg::WIDTH]);
      spif_io_pkg::REG_PRODUCT: reg_dout = spif_cfg_pkg::word_t'(spif_io_pkg::PRODUCT_ID);
      default:                  reg_dout = '0;
    endcase
  end

  // external reads return the low part of the captured bus word
  assign o_io_dout = internal ? reg_dout : i_wb_xi[spif_cfg_pkg::WIDTH-1:0];

endmodule

/* spif_io_top.sv */
`timescale 1ns/1ps

module spif_io_top (
  input  logic                   clk,
  input  logic                   arstn,
  // cpu side
  input  logic                   i_io_rd,
  input  logic                   i_io_wr,
  input  spif_cfg_pkg::addr_t    i_mem_addr,
  input  spif_cfg_pkg::word_t    i_din,
  output spif_cfg_pkg::word_t    o_io_dout,
  output logic                   o_p_hold,
  // uart
  input  logic                   i_u_ready,
  output logic                   o_u_wr,
  output spif_cfg_pkg::byte_t    o_u_dout,
  input  logic                   i_u_full,
  output logic                   o_u_rd,
  input  spif_cfg_pkg::byte_t    i_u_din,
  // wishbone master
  output spif_cfg_pkg::addr_t    o_adr,
  output spif_cfg_pkg::wb_data_t o_dat,
  input  spif_cfg_pkg::wb_data_t i_dat,
  output logic                   o_we,
  output logic                   o_stb,
  input  logic                   i_ack,
  output logic                   o_urxirq
);

  logic                   tx_valid, tx_ready;
  spif_cfg_pkg::byte_t    tx_data;
  logic                   rx_valid, rx_ready;
  spif_cfg_pkg::byte_t    rx_data;
  logic                   wb_req, wb_we, wb_busy;
  spif_cfg_pkg::xtra_t    wb_xo;
  spif_cfg_pkg::wb_data_t wb_xi;

  io_regs u_regs (
    .clk(clk), .arstn(arstn), .i_io_rd(i_io_rd), .i_io_wr(i_io_wr),
    .i_mem_addr(i_mem_addr), .i_din(i_din), .i_tx_ready(tx_ready),
    .i_rx_valid(rx_valid), .i_rx_data(rx_data), .i_wb_busy(wb_busy), .i_wb_xi(wb_xi),
    .o_io_dout(o_io_dout), .o_p_hold(o_p_hold), .o_tx_valid(tx_valid),
    .o_tx_data(tx_data), .o_rx_ready(rx_ready), .o_wb_req(wb_req), .o_wb_we(wb_we),
    .o_wb_xo(wb_xo), .o_urxirq(o_urxirq)
  );

  uart_tx_escaper u_tx (                    // cpu bytes out to the uart
    .clk(clk), .arstn(arstn), .i_tx_valid(tx_valid), .i_tx_data(tx_data),
    .i_u_ready(i_u_ready), .o_tx_ready(tx_ready), .o_u_wr(o_u_wr), .o_u_dout(o_u_dout)
  );

  uart_rx_unescaper u_rx (                  // raw uart bytes in
    .clk(clk), .arstn(arstn), .i_u_full(i_u_full), .i_u_din(i_u_din),
    .i_rx_ready(rx_ready), .o_u_rd(o_u_rd), .o_rx_valid(rx_valid), .o_rx_data(rx_data)
  );

  wb_master_bridge u_wb (                   // io above 0x000f
    .clk(clk), .arstn(arstn), .i_req(wb_req), .i_we(wb_we), .i_addr(i_mem_addr),
    .i_din(i_din), .i_xo(wb_xo), .i_dat(i_dat), .i_ack(i_ack), .o_busy(wb_busy),
    .o_xi(wb_xi), .o_adr(o_adr), .o_dat(o_dat), .o_we(o_we), .o_stb(o_stb)
  );

endmodule

/* tb_spif_io.sv */
`timescale 1ns/1ps

module tb_spif_io;

  localparam int N_TX = 40;                          // cpu bytes sent
  localparam int N_RX = 40;                          // bytes fed to the receiver
  localparam int N_WB = 12;                          // bus accesses per direction
  localparam int UART_BYTES = 2 * N_TX + 3 * N_RX;   // worst case with escapes and strays
  localparam int MAX_CYCLES = 64 * UART_BYTES + 32 * 2 * N_WB;

  logic clk = 1'b0;
  logic arstn, i_io_rd, i_io_wr, o_p_hold, i_u_ready, o_u_wr, i_u_full, o_u_rd;
  logic o_we, o_stb, i_ack, o_urxirq;
  spif_cfg_pkg::addr_t    i_mem_addr, o_adr, exp_adr;
  spif_cfg_pkg::word_t    i_din, o_io_dout;
  spif_cfg_pkg::byte_t    o_u_dout, i_u_din;
  spif_cfg_pkg::wb_data_t o_dat, i_dat, exp_dat, last_rdata;
  spif_cfg_pkg::byte_t    tx_q[$];                   // bytes seen on the uart tx pins
  spif_cfg_pkg::byte_t    raw_q[$];                  // raw bytes waiting in the uart
  spif_cfg_pkg::byte_t    enc_q[$];                  // model output stream
  logic   exp_we, rdy_d, wr_d, full_d, rd_d;
  logic   ack_d = 1'b0;
  integer seed = 73084;
  int     cyc = 0, errors = 0, checks = 0, irq_cnt = 0, wb_done = 0, done_cyc;

  spif_io_top i_dut (
    .clk(clk), .arstn(arstn), .i_io_rd(i_io_rd), .i_io_wr(i_io_wr), .i_mem_addr(i_mem_addr),
    .i_din(i_din), .o_io_dout(o_io_dout), .o_p_hold(o_p_hold), .i_u_ready(i_u_ready),
    .o_u_wr(o_u_wr), .o_u_dout(o_u_dout), .i_u_full(i_u_full), .o_u_rd(o_u_rd),
    .i_u_din(i_u_din), .o_adr(o_adr), .o_dat(o_dat), .i_dat(i_dat), .o_we(o_we),
    .o_stb(o_stb), .i_ack(i_ack), .o_urxirq(o_urxirq)
  );

  always #2 clk = ~clk;                              // 4 ns period

  always @(posedge clk) begin
    cyc = cyc + 1;                                   // also the watchdog
    if (cyc > MAX_CYCLES) begin
      $display("timeout after %0d cycles, a handshake never completed", MAX_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ========================================
  // compare tasks
  // ========================================
  task automatic check_byte(input string name, input spif_cfg_pkg::byte_t got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input spif_cfg_pkg::word_t got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_wb(input string name, input spif_cfg_pkg::wb_data_t got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // ========================================
  // uart and wishbone models
  // ========================================
  always @(posedge clk) begin
    #1;
    if (o_u_rd && raw_q.size() > 0)
      raw_q.delete(0);                               // byte taken by the dut
    i_u_full  = (raw_q.size() > 0) && (($random(seed) & 3) != 0);
    i_u_din   = (raw_q.size() > 0) ? raw_q[0] : 8'h00;
    i_u_ready = ($random(seed) & 3) != 0;            // sink stalls now and then
    i_ack     = o_stb && (($random(seed) & 3) == 0); // random ack delay
    i_dat     = $random(seed);
  end

  always @(negedge clk) begin
    if (o_u_wr) begin
      if (!rdy_d || wr_d)
        report_error("uart write strobe without ready or right after another strobe");
      tx_q.push_back(o_u_dout);
    end
    if (o_u_rd && (!full_d || rd_d))
      report_error("uart read strobe without a full uart or right after another strobe");
    if (o_urxirq)
      irq_cnt++;
    if (ack_d && o_stb)
      report_error("o_stb still high in the cycle after acknowledge");
    if (o_stb && i_ack) begin                        // access ends on the next edge
      wb_done++;
      check_word("o_adr", spif_cfg_pkg::word_t'(o_adr), spif_cfg_pkg::word_t'(exp_adr));
      if (o_we !== exp_we)
        report_error($sformatf("Mismatch o_we: got %h, expected %h", o_we, exp_we));
      if (exp_we)
        check_wb("o_dat", o_dat, exp_dat);
      else
        last_rdata = i_dat;                          // word the bridge captures
    end
    rdy_d  = i_u_ready;
    wr_d   = o_u_wr;
    full_d = i_u_full;
    rd_d   = o_u_rd;
    ack_d  = i_ack;
  end

  // ========================================
  // cpu side and reference model
  // ========================================
  function automatic spif_cfg_pkg::addr_t reg_addr(input spif_io_pkg::reg_ofs_t ofs);
    return {11'b0, ofs};
  endfunction

  function automatic spif_cfg_pkg::byte_t rand_byte();
    spif_cfg_pkg::byte_t b;
    b = $random(seed);
    return b[0] ? {6'b000100, b[2:1]} : b;           // half land in 10h..13h
  endfunction

  task automatic encode(input spif_cfg_pkg::byte_t b);
    if (b[7:2] == spif_io_pkg::ESC_TOP6) begin
      enc_q.push_back(spif_io_pkg::ESC_BYTE);        // prefix, then low bits
      enc_q.push_back({6'b000000, b[1:0]});
    end else begin
      enc_q.push_back(b);
    end
  endtask

  task automatic wait_hold_low(output spif_cfg_pkg::word_t q);
    logic h;
    h = 1'b1;
    while (h) begin
      @(negedge clk);
      h        = o_p_hold;
      q        = o_io_dout;                          // value at the coming edge
      done_cyc = cyc;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic cpu_access(input logic wr, input spif_cfg_pkg::addr_t a,
                            input spif_cfg_pkg::word_t d, output spif_cfg_pkg::word_t q);
    i_io_wr    = wr;
    i_io_rd    = !wr;
    i_mem_addr = a;
    i_din      = d;
    wait_hold_low(q);
    i_io_wr    = 1'b0;
    i_io_rd    = 1'b0;                               // address stays for the read mux
  endtask

  task automatic bus_access(input logic we, input spif_cfg_pkg::xtra_t x);
    spif_cfg_pkg::word_t d, q;
    exp_adr = 16 + ({$random(seed)} % 32752);        // anywhere from 10h up
    d       = $random(seed);
    exp_we  = we;
    exp_dat = {x, d};
    cpu_access(we, exp_adr, d, q);
    wait_hold_low(q);                                // bridge done when hold drops
    if (!we) begin
      check_word("o_io_dout", q, last_rdata[23:0]);
      cpu_access(1'b0, reg_addr(spif_io_pkg::REG_WBX), '0, q);
      check_word("REG_WBX", q, spif_cfg_pkg::word_t'(last_rdata[31:24]));
    end
  endtask

  task automatic test_done(input string name, input int err0);
    $display("%s: %s (%0d errors)", name, (errors == err0) ? "ok" : "failed", errors - err0);
  endtask

  initial begin
    spif_cfg_pkg::byte_t b;
    spif_cfg_pkg::byte_t exp_q[$];
    spif_cfg_pkg::word_t q, d, c1;
    int                  i, n, err0, irq0, wb0, k1;

    arstn      = 1'b0;
    i_io_rd    = 1'b0;
    i_io_wr    = 1'b0;
    i_mem_addr = '0;
    i_din      = '0;
    i_u_ready  = 1'b0;
    i_u_full   = 1'b0;
    i_u_din    = '0;
    i_ack      = 1'b0;
    i_dat      = '0;
    repeat (3) @(posedge clk);
    if ({o_u_wr, o_u_rd, o_stb, o_we, o_p_hold, o_urxirq} !== 6'h00)
      report_error($sformatf("Mismatch {o_u_wr,o_u_rd,o_stb,o_we,o_p_hold,o_urxirq}: got %h, expected %h",
                             {o_u_wr, o_u_rd, o_stb, o_we, o_p_hold, o_urxirq}, 6'h00));
    #1;
    arstn = 1'b1;

    // transmit escaping
    err0 = errors;
    for (i = 0; i < N_TX; i++) begin
      b = rand_byte();
      encode(b);
      d = $random(seed);
      cpu_access(1'b1, reg_addr(spif_io_pkg::REG_UART), {d[23:8], b}, q);
    end
    while (tx_q.size() < enc_q.size())
      @(negedge clk);
    @(posedge clk);
    #1;
    if (tx_q.size() != enc_q.size())
      report_error("uart tx byte count differs from the encoded stream");
    for (i = 0; i < enc_q.size(); i++)
      check_byte("o_u_dout", tx_q[i], enc_q[i]);
    test_done("transmit escaping", err0);

    // receive decoding, stray 11h/13h must vanish
    err0 = errors;
    enc_q.delete();
    for (i = 0; i < N_RX; i++) begin
      b = rand_byte();
      exp_q.push_back(b);
      if (($random(seed) & 7) == 0)
        enc_q.push_back((($random(seed) & 1) != 0) ? 8'h13 : 8'h11);
      encode(b);
    end
    irq0  = irq_cnt;
    raw_q = enc_q;                                   // hand the stream to the uart source
    n     = 0;
    while (n < N_RX) begin
      cpu_access(1'b0, reg_addr(spif_io_pkg::REG_RXFULL), '0, q);
      if (q[0]) begin
        cpu_access(1'b0, reg_addr(spif_io_pkg::REG_UART), '0, q);
        check_word("REG_UART", q, spif_cfg_pkg::word_t'(exp_q[n]));
        cpu_access(1'b0, reg_addr(spif_io_pkg::REG_RXFULL), '0, q);
        check_word("REG_RXFULL", q, '0);
        n++;
      end
    end
    test_done("receive decoding", err0);
    err0 = errors;
    check_word("o_urxirq count", spif_cfg_pkg::word_t'(irq_cnt - irq0), N_RX);
    test_done("rx interrupt", err0);

    // wishbone writes then reads
    err0 = errors;
    wb0  = wb_done;
    d    = $random(seed);
    cpu_access(1'b1, reg_addr(spif_io_pkg::REG_WBX), d, q);
    for (i = 0; i < N_WB; i++)
      bus_access(1'b1, d[7:0]);
    check_word("wishbone write count", spif_cfg_pkg::word_t'(wb_done - wb0), N_WB);
    test_done("wishbone write", err0);
    err0 = errors;
    wb0  = wb_done;
    for (i = 0; i < N_WB; i++)
      bus_access(1'b0, d[7:0]);
    check_word("wishbone read count", spif_cfg_pkg::word_t'(wb_done - wb0), N_WB);
    test_done("wishbone read", err0);

    // identity and counter
    err0 = errors;
    cpu_access(1'b0, reg_addr(spif_io_pkg::REG_PRODUCT), '0, q);
    check_word("REG_PRODUCT", q, spif_cfg_pkg::word_t'(spif_io_pkg::PRODUCT_ID));
    cpu_access(1'b0, reg_addr(spif_io_pkg::REG_CYCLES), '0, c1);
    k1 = done_cyc;
    check_word("REG_CYCLES", c1, spif_cfg_pkg::word_t'(k1 - 3)); // zero out of reset
    repeat (1 + ($random(seed) & 15)) @(posedge clk);
    #1;
    cpu_access(1'b0, reg_addr(spif_io_pkg::REG_CYCLES), '0, q);
    check_word("REG_CYCLES step", q - c1, spif_cfg_pkg::word_t'(done_cyc - k1));
    test_done("identity and counter", err0);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* sources.f */
spif_cfg_pkg.sv
spif_io_pkg.sv
uart_tx_escaper.sv
uart_rx_unescaper.sv
wb_master_bridge.sv
io_regs.sv
spif_io_top.sv
tb_spif_io.sv

/* Makefile */
# Verilator build and run for the spif io testbench

VERILATOR ?= verilator
TOP       ?= tb_spif_io
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TESTS PASSED

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log search decides pass or fail
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
